// File: common/dd_config.svh
`ifndef DD_CONFIG_SVH
`define DD_CONFIG_SVH

// ==========================================================================
// Disk drive register block sizing
// ==========================================================================

// Width of the CPU byte address. The top bit selects the sector window.
`define DD_ADDR_W 9

// Number of 32-bit words held by the sector buffer.
`define DD_SECTOR_WORDS 64

// Width of the free-running seek timer.
`define DD_SEEK_W 32

`endif

// File: common/dd_pkg.sv
`include "dd_config.svh"

package dd_pkg;

    // ======================================================================
    // Address map and SCR bit positions
    // ======================================================================

    localparam int SECTOR_SEL_BIT = `DD_ADDR_W - 1;
    localparam int SBUF_AW = $clog2(`DD_SECTOR_WORDS);

    localparam int SCR_HARD_RESET = 0;
    localparam int SCR_HARD_RESET_CLR = 1;
    localparam int SCR_CMD_PENDING = 2;
    localparam int SCR_CMD_READY = 3;
    localparam int SCR_DISK_INSERTED = 6;
    localparam int SCR_DISK_CHANGED = 7;
    localparam int SCR_SEEK_CLEAR = 20;

    // Register slots, decoded from byte address bits 4:2.
    typedef enum logic [2:0] {
        SCR,
        CMD_DATA,
        HEAD_TRACK,
        SECTOR_INFO,
        DRIVE_ID,
        SEEK_TIMER
    } dd_reg_e;

    typedef enum logic [1:0] {
        IDLE,
        PENDING,
        RESPOND
    } drive_state_e;

    // ======================================================================
    // Port bundles
    // ======================================================================

    typedef struct packed {
        logic                  request;
        logic [`DD_ADDR_W-1:0] address;
        logic [31:0]           wdata;
        logic [3:0]            wmask;
    } cpu_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic        req;
        logic [7:0]  cmd;
        logic [15:0] data;
    } host_cmd_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] data;
    } host_rsp_t;

    // Drive controller to register file.
    typedef struct packed {
        logic        hard_reset;
        logic        cmd_pending;
        logic [7:0]  cmd;
        logic [15:0] data;
    } drive_status_t;

    // Register file to drive controller. Both flags are single-cycle pulses.
    typedef struct packed {
        logic        cmd_ready;
        logic        hard_reset_clear;
        logic [15:0] data;
    } drive_ctrl_t;

    typedef struct packed {
        logic [SBUF_AW-1:0] addr;
        logic               valid;
        logic               write;
        logic [31:0]        wdata;
    } sbuf_port_t;

endpackage

// File: dd/dd_cpu_regs.sv
`timescale 1ns/1ps
`include "dd_config.svh"

module dd_cpu_regs import dd_pkg::*; (
    input  logic          sys,
    input  logic          rst,
    input  cpu_req_t      bus_req,
    output cpu_rsp_t      bus_rsp,
    input  drive_status_t status,
    output drive_ctrl_t   ctrl,
    output sbuf_port_t    sbuf,
    input  logic [31:0]   sbuf_rdata
);

    logic                  sector_sel;
    logic                  reg_access;
    logic                  full_mask;
    logic                  low_mask;
    dd_reg_e               reg_id;

    logic                  ack;
    logic                  rd_sector;
    dd_reg_e               rd_reg;
    logic [31:0]           scr_rd;

    logic                  cmd_ready_pulse;
    logic                  hr_clear_pulse;
    logic                  disk_inserted;
    logic                  disk_changed;
    logic [12:0]           head_track;
    logic                  index_lock;
    logic [15:0]           drive_id;
    logic [15:0]           resp_data;
    logic [31:0]           sector_info;
    logic [`DD_SEEK_W-1:0] seek_timer;

    assign sector_sel = bus_req.address[SECTOR_SEL_BIT];
    assign reg_access = bus_req.request && !sector_sel;
    assign full_mask  = &bus_req.wmask;
    assign low_mask   = &bus_req.wmask[1:0];
    assign reg_id     = dd_reg_e'(bus_req.address[4:2]);

    // ======================================================================
    // Control state: ack, SCR flags, pulses and the seek timer
    // ======================================================================

    always_ff @(posedge sys) begin
        if (rst) begin
            ack             <= 1'b0;
            cmd_ready_pulse <= 1'b0;
            hr_clear_pulse  <= 1'b0;
            disk_inserted   <= 1'b0;
            disk_changed    <= 1'b0;
            seek_timer      <= '0;
        end else begin
            ack             <= bus_req.request;
            cmd_ready_pulse <= 1'b0;
            hr_clear_pulse  <= 1'b0;
            if (!(&seek_timer)) begin
                seek_timer <= seek_timer + 1'b1;
            end
            if (reg_access && reg_id == SCR && full_mask) begin
                // A clear request overrides the increment above.
                if (bus_req.wdata[SCR_SEEK_CLEAR]) begin
                    seek_timer <= '0;
                end
                disk_changed    <= bus_req.wdata[SCR_DISK_CHANGED];
                disk_inserted   <= bus_req.wdata[SCR_DISK_INSERTED];
                cmd_ready_pulse <= bus_req.wdata[SCR_CMD_READY];
                hr_clear_pulse  <= bus_req.wdata[SCR_HARD_RESET_CLR];
            end
        end
    end

    // Data registers and the latched read selection.
    always_ff @(posedge sys) begin
        rd_sector <= sector_sel;
        rd_reg    <= reg_id;
        if (reg_access) begin
            case (reg_id)
                CMD_DATA: if (low_mask) resp_data <= bus_req.wdata[15:0];
                HEAD_TRACK: if (low_mask) {index_lock, head_track} <= bus_req.wdata[13:0];
                SECTOR_INFO: if (full_mask) sector_info <= bus_req.wdata;
                DRIVE_ID: if (low_mask) drive_id <= bus_req.wdata[15:0];
                default: ;
            endcase
        end
    end

    // ======================================================================
    // Read data
    // ======================================================================

    always_comb begin
        scr_rd = '0;
        scr_rd[SCR_HARD_RESET]    = status.hard_reset;
        scr_rd[SCR_CMD_PENDING]   = status.cmd_pending;
        scr_rd[SCR_DISK_INSERTED] = disk_inserted;
        scr_rd[SCR_DISK_CHANGED]  = disk_changed;
    end

    always_comb begin
        bus_rsp.ack   = ack;
        bus_rsp.rdata = '0;
        if (ack) begin
            if (rd_sector) begin
                bus_rsp.rdata = sbuf_rdata;
            end else begin
                case (rd_reg)
                    SCR:         bus_rsp.rdata = scr_rd;
                    CMD_DATA:    bus_rsp.rdata = {8'd0, status.cmd, status.data};
                    HEAD_TRACK:  bus_rsp.rdata = {18'd0, index_lock, head_track};
                    SECTOR_INFO: bus_rsp.rdata = sector_info;
                    DRIVE_ID:    bus_rsp.rdata = {16'd0, drive_id};
                    SEEK_TIMER:  bus_rsp.rdata = 32'(seek_timer);
                    default:     bus_rsp.rdata = '0;
                endcase
            end
        end
    end

    // The buffer keeps the bytes in reversed order
    assign sbuf.addr  = bus_req.address[SBUF_AW+1:2];
    assign sbuf.valid = bus_req.request && sector_sel;
    assign sbuf.write = sbuf.valid && full_mask;
    assign sbuf.wdata = {<<8{bus_req.wdata}};

    assign ctrl = '{cmd_ready: cmd_ready_pulse, hard_reset_clear: hr_clear_pulse, data: resp_data};

endmodule

// File: dd/dd_sector_buffer.sv
`timescale 1ns/1ps
`include "dd_config.svh"

module dd_sector_buffer import dd_pkg::*; (
    input  logic        sys,
    input  sbuf_port_t  sbuf,
    output logic [31:0] rdata
);

    // ======================================================================
    // Sector storage
    // ======================================================================

    logic [31:0] mem [`DD_SECTOR_WORDS];

    // Single port, read-before-write. The read word lands on the cycle
    // the CPU bus raises ack, so no extra wait state is needed.
    always_ff @(posedge sys) begin
        if (sbuf.valid) begin
            if (sbuf.write) begin
                mem[sbuf.addr] <= sbuf.wdata;
            end
            rdata <= mem[sbuf.addr];
        end
    end

endmodule

// File: dd/dd_drive_ctrl.sv
`timescale 1ns/1ps

module dd_drive_ctrl import dd_pkg::*; (
    input  logic          sys,
    input  logic          rst,
    input  host_cmd_t     host_cmd,
    output host_rsp_t     host_rsp,
    input  logic          host_reset,
    input  drive_ctrl_t   ctrl,
    output drive_status_t status
);

    drive_state_e state;
    logic         hard_reset;
    logic [7:0]   cmd_q;
    logic [15:0]  data_q;
    logic [15:0]  rsp_data_q;

    // ======================================================================
    // Host handshake
    // ======================================================================

    // IDLE waits for req, PENDING waits for the CPU to answer, RESPOND
    // holds ack until the host lets go of req.
    always_ff @(posedge sys) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (host_cmd.req) begin
                        state <= PENDING;
                    end
                end
                PENDING: begin
                    // A host that withdraws its request gets no answer.
                    if (!host_cmd.req) begin
                        state <= IDLE;
                    end else if (ctrl.cmd_ready) begin
                        state <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (!host_cmd.req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Command and response words.
    always_ff @(posedge sys) begin
        if (state == IDLE && host_cmd.req) begin
            cmd_q  <= host_cmd.cmd;
            data_q <= host_cmd.data;
        end
        if (state == PENDING && ctrl.cmd_ready) begin
            rsp_data_q <= ctrl.data;
        end
    end

    // ======================================================================
    // Hard reset request
    // ======================================================================

    // Sticky until the CPU clears it; a new host pulse wins over a clear.
    always_ff @(posedge sys) begin
        if (rst) begin
            hard_reset <= 1'b0;
        end else if (host_reset) begin
            hard_reset <= 1'b1;
        end else if (ctrl.hard_reset_clear) begin
            hard_reset <= 1'b0;
        end
    end

    assign host_rsp = '{ack: (state == RESPOND), data: rsp_data_q};

    assign status = '{
        hard_reset:  hard_reset,
        cmd_pending: (state == PENDING),
        cmd:         cmd_q,
        data:        data_q
    };

endmodule

// File: hdl/dd_top.sv
`timescale 1ns/1ps

module dd_top import dd_pkg::*; (
    input  logic      sys,
    input  logic      rst,
    input  cpu_req_t  bus_req,
    output cpu_rsp_t  bus_rsp,
    input  host_cmd_t host_cmd,
    output host_rsp_t host_rsp,
    input  logic      host_reset
);

    drive_status_t drv_status;
    drive_ctrl_t   drv_ctrl;
    sbuf_port_t    sbuf;
    logic [31:0]   sbuf_rdata;

    // ======================================================================
    // CPU side
    // ======================================================================

    dd_cpu_regs u_regs (
        .sys        (sys),
        .rst        (rst),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .status     (drv_status),
        .ctrl       (drv_ctrl),
        .sbuf       (sbuf),
        .sbuf_rdata (sbuf_rdata)
    );

    dd_sector_buffer u_sbuf (
        .sys   (sys),
        .sbuf  (sbuf),
        .rdata (sbuf_rdata)
    );

    // Host side.
    dd_drive_ctrl u_drive (
        .sys        (sys),
        .rst        (rst),
        .host_cmd   (host_cmd),
        .host_rsp   (host_rsp),
        .host_reset (host_reset),
        .ctrl       (drv_ctrl),
        .status     (drv_status)
    );

endmodule

// File: bench/dd_props.sv
`timescale 1ns/1ps

module dd_props import dd_pkg::*; (
    input logic      sys,
    input logic      rst,
    input cpu_req_t  bus_req,
    input cpu_rsp_t  bus_rsp,
    input host_cmd_t host_cmd,
    input host_rsp_t host_rsp,
    input logic      cmd_pending
);

    // ======================================================================
    // CPU bus
    // ======================================================================

    // Every request is answered on the next cycle, and no ack comes alone.
    ack_after_request: assert property (
        @(posedge sys) disable iff (rst) bus_req.request |=> bus_rsp.ack
    ) else $error("bus ack missing one cycle after request");

    ack_needs_request: assert property (
        @(posedge sys) disable iff (rst) bus_rsp.ack |-> $past(bus_req.request)
    ) else $error("bus ack without a request one cycle earlier");

    // ======================================================================
    // Host port
    // ======================================================================

    host_ack_needs_req: assert property (
        @(posedge sys) disable iff (rst) $rose(host_rsp.ack) |-> host_cmd.req
    ) else $error("host ack rose while req was low");

    host_ack_follows_req: assert property (
        @(posedge sys) disable iff (rst) $fell(host_cmd.req) |=> !host_rsp.ack
    ) else $error("host ack still high one cycle after req fell");

    pending_low_after_reset: assert property (
        @(posedge sys) rst |=> !cmd_pending
    ) else $error("cmd_pending set right after reset");

endmodule

bind dd_top dd_props u_props (
    .sys         (sys),
    .rst         (rst),
    .bus_req     (bus_req),
    .bus_rsp     (bus_rsp),
    .host_cmd    (host_cmd),
    .host_rsp    (host_rsp),
    .cmd_pending (drv_status.cmd_pending)
);

// File: bench/dd_tb.sv
`timescale 1ns/1ps
`include "dd_config.svh"

module dd_tb import dd_pkg::*; ();

    // The six tests need roughly 300 cycles, so this leaves a wide margin.
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int ACK_WAIT       = 4;
    localparam int HOST_WAIT      = 16;

    logic      sys;
    logic      rst;
    cpu_req_t  bus_req;
    cpu_rsp_t  bus_rsp;
    host_cmd_t host_cmd;
    host_rsp_t host_rsp;
    logic      host_reset;

    int checks;
    int failures;
    int tests_failed;
    int cycles;
    bit run_done;

    dd_top uut (
        .sys        (sys),
        .rst        (rst),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .host_cmd   (host_cmd),
        .host_rsp   (host_rsp),
        .host_reset (host_reset)
    );

    initial begin
        sys = 1'b0;
        forever #2 sys = ~sys;
    end

    initial begin
        cycles = 0;
        while (!run_done && cycles < TIMEOUT_CYCLES) begin
            @(posedge sys);
            cycles++;
        end
        if (!run_done) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    // ======================================================================
    // Address helpers and result checks
    // ======================================================================

    function automatic logic [`DD_ADDR_W-1:0] reg_addr(input dd_reg_e slot);
        return {4'b0000, slot, 2'b00};
    endfunction

    function automatic logic [`DD_ADDR_W-1:0] sector_addr(input logic [SBUF_AW-1:0] word);
        return {1'b1, word, 2'b00};
    endfunction

    // The sector buffer returns the CPU's bytes in reverse order.
    function automatic logic [31:0] byte_reverse(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    task automatic report_failure(input string what);
        failures++;
        $display("%s", what);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            report_failure($sformatf("error: %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_reg(input dd_reg_e slot, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            report_failure($sformatf("error: %s got 0x%08h expected 0x%08h",
                                     slot.name(), got, exp));
        end
    endtask

    // Host data is only compared while it is meant to be valid.
    task automatic check_rsp(input string name, input host_rsp_t got, input host_rsp_t exp,
                             input bit data_valid);
        checks++;
        if (got.ack !== exp.ack || (data_valid && got.data !== exp.data)) begin
            report_failure($sformatf(
                "error: %s got ack 0x%0h data 0x%04h expected ack 0x%0h data 0x%04h",
                name, got.ack, got.data, exp.ack, exp.data));
        end
    endtask

    task automatic finish_test(input string name, input int failures_at_start);
        if (failures == failures_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d failed checks", name, failures - failures_at_start);
        end
    endtask

    // ======================================================================
    // Bus and host drivers
    // ======================================================================

    task automatic cpu_access(input logic [`DD_ADDR_W-1:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wmask, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge sys);
        bus_req <= '{request: 1'b1, address: addr, wdata: wdata, wmask: wmask};
        @(posedge sys);
        bus_req <= '0;
        @(negedge sys);
        while (!bus_rsp.ack && waited < ACK_WAIT) begin
            @(negedge sys);
            waited++;
        end
        if (!bus_rsp.ack) begin
            report_failure($sformatf("No bus ack for address 0x%03h", addr));
        end
        rdata = bus_rsp.rdata;
    endtask

    task automatic cpu_write(input logic [`DD_ADDR_W-1:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wmask);
        logic [31:0] unused;
        cpu_access(addr, wdata, wmask, unused);
    endtask

    task automatic cpu_read(input logic [`DD_ADDR_W-1:0] addr, output logic [31:0] rdata);
        cpu_access(addr, 32'h0, 4'h0, rdata);
    endtask

    task automatic host_command(input logic [7:0] cmd, input logic [15:0] data);
        @(posedge sys);
        host_cmd <= '{req: 1'b1, cmd: cmd, data: data};
    endtask

    task automatic wait_host_ack(input logic level);
        int waited;
        waited = 0;
        @(negedge sys);
        while (host_rsp.ack !== level && waited < HOST_WAIT) begin
            @(negedge sys);
            waited++;
        end
        if (host_rsp.ack !== level) begin
            report_failure($sformatf("Host ack did not reach %0d within %0d cycles",
                                     level, HOST_WAIT));
        end
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================

    task automatic test_register_access();
        int          start;
        logic [31:0] value;
        logic [31:0] rdata;
        start = failures;
        value = $urandom;
        cpu_write(reg_addr(DRIVE_ID), value, 4'hf);
        cpu_read(reg_addr(DRIVE_ID), rdata);
        check_reg(DRIVE_ID, rdata, value & 32'h0000_ffff);
        value = $urandom;
        cpu_write(reg_addr(HEAD_TRACK), value, 4'b0011);
        cpu_read(reg_addr(HEAD_TRACK), rdata);
        check_reg(HEAD_TRACK, rdata, value & 32'h0000_3fff);
        // SCR ignores anything short of a full mask, so it keeps its reset value.
        cpu_write(reg_addr(SCR), 32'h0000_00c8, 4'b0111);
        cpu_read(reg_addr(SCR), rdata);
        check_reg(SCR, rdata, 32'h0);
        finish_test("register access", start);
    endtask

    task automatic test_sector_buffer();
        int                 start;
        logic [31:0]        model [`DD_SECTOR_WORDS];
        bit                 written [`DD_SECTOR_WORDS];
        logic [SBUF_AW-1:0] word;
        logic [31:0]        value;
        logic [31:0]        rdata;
        start = failures;
        for (int i = 0; i < 16; i++) begin
            word  = SBUF_AW'($urandom);
            value = $urandom;
            cpu_write(sector_addr(word), value, 4'hf);
            model[word]   = byte_reverse(value);
            written[word] = 1'b1;
        end
        cpu_write(sector_addr(word), ~value, 4'b1110);
        for (int i = 0; i < `DD_SECTOR_WORDS; i++) begin
            if (written[i]) begin
                cpu_read(sector_addr(SBUF_AW'(i)), rdata);
                check_word($sformatf("sector[%0d]", i), rdata, model[i]);
            end
        end
        finish_test("sector buffer", start);
    endtask

    task automatic test_host_command();
        int          start;
        int          polls;
        logic [7:0]  cmd;
        logic [15:0] data;
        logic [15:0] resp;
        logic [31:0] rdata;
        start = failures;
        cmd   = 8'($urandom);
        data  = 16'($urandom);
        resp  = 16'($urandom);
        host_command(cmd, data);
        polls = 0;
        rdata = '0;
        while (!rdata[SCR_CMD_PENDING] && polls < 8) begin
            cpu_read(reg_addr(SCR), rdata);
            polls++;
        end
        checks++;
        if (!rdata[SCR_CMD_PENDING]) begin
            report_failure("cmd_pending never showed up in SCR after the host request");
        end
        cpu_read(reg_addr(CMD_DATA), rdata);
        check_reg(CMD_DATA, rdata, {8'h00, cmd, data});
        check_rsp("host_rsp before cmd_ready", host_rsp, '{ack: 1'b0, data: 16'h0}, 1'b0);
        cpu_write(reg_addr(CMD_DATA), {16'h0, resp}, 4'b0011);
        cpu_write(reg_addr(SCR), 32'h1 << SCR_CMD_READY, 4'hf);
        wait_host_ack(1'b1);
        check_rsp("host_rsp", host_rsp, '{ack: 1'b1, data: resp}, 1'b1);
        @(posedge sys);
        host_cmd.req <= 1'b0;
        // The controller drops ack one cycle after it sees req low.
        @(posedge sys);
        @(negedge sys);
        check_rsp("host_rsp after release", host_rsp, '{ack: 1'b0, data: 16'h0}, 1'b0);
        cpu_read(reg_addr(SCR), rdata);
        check_reg(SCR, rdata, 32'h0);
        finish_test("host command", start);
    endtask

    task automatic test_hard_reset();
        int          start;
        logic [31:0] rdata;
        start = failures;
        @(posedge sys);
        host_reset <= 1'b1;
        @(posedge sys);
        host_reset <= 1'b0;
        cpu_read(reg_addr(SCR), rdata);
        check_reg(SCR, rdata, 32'h1 << SCR_HARD_RESET);
        cpu_write(reg_addr(DRIVE_ID), $urandom, 4'hf);
        cpu_write(reg_addr(SCR), 32'h1 << SCR_DISK_INSERTED, 4'hf);
        cpu_read(reg_addr(SCR), rdata);
        check_reg(SCR, rdata, (32'h1 << SCR_HARD_RESET) | (32'h1 << SCR_DISK_INSERTED));
        cpu_write(reg_addr(SCR), 32'h1 << SCR_HARD_RESET_CLR, 4'hf);
        cpu_read(reg_addr(SCR), rdata);
        check_reg(SCR, rdata, 32'h0);
        finish_test("hard reset", start);
    endtask

    task automatic test_seek_timer();
        int          start;
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] third;
        start = failures;
        cpu_write(reg_addr(SCR), 32'h1 << SCR_SEEK_CLEAR, 4'hf);
        cpu_read(reg_addr(SEEK_TIMER), first);
        repeat (4 + $urandom_range(20)) @(posedge sys);
        cpu_read(reg_addr(SEEK_TIMER), second);
        cpu_write(reg_addr(SCR), 32'h1 << SCR_SEEK_CLEAR, 4'hf);
        cpu_read(reg_addr(SEEK_TIMER), third);
        checks += 3;
        if (first == 0) begin
            report_failure("Seek timer still read zero after the clear");
        end
        if (second <= first) begin
            report_failure($sformatf("Seek timer did not advance: 0x%08h then 0x%08h",
                                     first, second));
        end
        if (third >= second) begin
            report_failure($sformatf("Seek timer clear did not take: 0x%08h after 0x%08h",
                                     third, second));
        end
        finish_test("seek timer", start);
    endtask

    task automatic test_disk_flags();
        int          start;
        logic [31:0] flags [4];
        logic [31:0] rdata;
        start = failures;
        // Bit 6 is disk_inserted and bit 7 is disk_changed.
        flags = '{32'h40, 32'h80, 32'hc0, 32'h00};
        foreach (flags[i]) begin
            cpu_write(reg_addr(SCR), flags[i], 4'hf);
            cpu_read(reg_addr(SCR), rdata);
            check_reg(SCR, rdata, flags[i]);
        end
        finish_test("disk flags", start);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        void'($urandom(32'h3d5a));
        rst          = 1'b1;
        bus_req      = '0;
        host_cmd     = '0;
        host_reset   = 1'b0;
        checks       = 0;
        failures     = 0;
        tests_failed = 0;
        repeat (5) @(posedge sys);
        rst <= 1'b0;
        test_register_access();
        test_sector_buffer();
        test_host_command();
        test_hard_reset();
        test_seek_timer();
        test_disk_flags();
        run_done = 1'b1;
        $display("tests 6, failed tests %0d, checks %0d, failed checks %0d",
                 tests_failed, checks, failures);
        if (failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: disk_drive.f
+incdir+common
common/dd_pkg.sv
dd/dd_cpu_regs.sv
dd/dd_sector_buffer.sv
dd/dd_drive_ctrl.sv
hdl/dd_top.sv
bench/dd_props.sv
bench/dd_tb.sv

// File: Bender.yml
package:
  name: disk_drive

sources:
  - include_dirs:
      - common
    files:
      - common/dd_pkg.sv
      - dd/dd_cpu_regs.sv
      - dd/dd_sector_buffer.sv
      - dd/dd_drive_ctrl.sv
      - hdl/dd_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - bench/dd_props.sv
      - bench/dd_tb.sv
